/* hw/ramSysPkg.sv */
package ramSysPkg;

	// Refresh timing, in CLK cycles
	localparam int refreshPeriod = 64; // One refresh credit per period
	localparam int refreshUrgentLevel = 4; // Pending credits before refresh may stall the CPU
	localparam int refreshCountMax = 7; // Pending count saturates here

	// CPU word address A[23:1]
	typedef logic [23:1] addrT;

	// Multiplexed row/column address on the DRAM pins
	typedef logic [11:0] dramAddrT;

	// Address bits 23:22 pick the memory region
	typedef logic [1:0] regionT;

	localparam regionT ramRegion = 2'd0;
	localparam regionT romRegion = 2'd1;

	// Counter widths that follow from the refresh constants
	typedef logic [$clog2(refreshPeriod)-1:0] periodCntT;
	typedef logic [$clog2(refreshCountMax+1)-1:0] refCntT;

	// Sequencer states
	// The encoding matches the state numbers used on the board
	typedef enum logic [2:0] {
		stIdle      = 3'd0, // Waiting for a RAM cycle or a refresh request
		stPrecharge = 3'd1, // Extra RAS precharge before an urgent refresh in a long RAM cycle
		stRefCas    = 3'd2, // CAS asserted ahead of RAS
		stRefRas1   = 3'd3,
		stRefRas2   = 3'd4,
		stAccRow    = 3'd5, // Row address on RA, RAS low
		stAccCol    = 3'd6, // Column address on RA, CAS follows half a cycle later
		stRecover   = 3'd7  // RAS precharge after an access or a refresh
	} dramStateE;

endpackage

/* hw/busCycleDecoder.sv */
`timescale 1ns/1ps

module busCycleDecoder (
	input  logic            CLK,
	input  logic            arstN,
	input  ramSysPkg::addrT A,
	input  logic            nAS,
	output logic            BACT,
	output logic            RAMCS,
	output logic            ROMCS
);

	import ramSysPkg::*;

	regionT region;

	assign region = A[23:22];

	// Bus cycle active level
	// nAS is sampled on every rising edge, so BACT lags the strobe by up to one cycle
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			BACT <= 1'b0;
		end else begin
			BACT <= ~nAS;
		end
	end

	// Region decode is gated by the strobe so nothing is selected between cycles
	assign RAMCS = ~nAS && (region == ramRegion);
	assign ROMCS = ~nAS && (region == romRegion);

	// The upper half of the map is left open, with neither chip select active there

	// Two selects at once would drive DRAM and flash onto the data bus together
	selectsExclusive: assert property (
		@(posedge CLK) disable iff (!arstN)
		!(RAMCS && ROMCS)
	) else $error("RAMCS and ROMCS both active");

endmodule

/* hw/refreshTimer.sv */
`timescale 1ns/1ps

module refreshTimer (
	input  logic CLK,
	input  logic arstN,
	input  logic RefAck,
	output logic RefReq,
	output logic RefUrgent
);

	import ramSysPkg::*;

	periodCntT periodCnt;
	refCntT    pendCnt; // Refreshes owed to the DRAM
	logic      refAckR;
	logic      credit;
	logic      ackRise;

	assign credit = (periodCnt == periodCntT'(refreshPeriod - 1));

	// Period counter runs freely and wraps once per period
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			periodCnt <= '0;
		end else if (credit) begin
			periodCnt <= '0;
		end else begin
			periodCnt <= periodCnt + 1'b1;
		end
	end

	// RefAck stays high for two cycles, so only its leading edge counts
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			refAckR <= 1'b0;
		end else begin
			refAckR <= RefAck;
		end
	end

	assign ackRise = RefAck && !refAckR;

	// A credit and an ack in the same cycle cancel out
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			pendCnt <= '0;
		end else if (credit && !ackRise) begin
			if (pendCnt != refCntT'(refreshCountMax)) begin
				pendCnt <= pendCnt + 1'b1; // Saturate when refresh is starved for a long time
			end
		end else if (ackRise && !credit) begin
			if (pendCnt != '0) begin
				pendCnt <= pendCnt - 1'b1;
			end
		end
	end

	assign RefReq = (pendCnt != '0);
	assign RefUrgent = (pendCnt >= refCntT'(refreshUrgentLevel));

	// The controller only starts a refresh on a request, so every ack finds a credit
	ackHasCredit: assert property (
		@(posedge CLK) disable iff (!arstN)
		ackRise |-> (pendCnt != '0)
	) else $error("Refresh acknowledged with no pending credit");

	// The count moves by one at most, which rules out a wrap from zero to the top
	countNoWrap: assert property (
		@(posedge CLK) disable iff (!arstN)
		($past(pendCnt) == '0) |-> (pendCnt <= refCntT'(1))
	) else $error("Pending refresh count wrapped");

endmodule

/* hw/dramController.sv */
`timescale 1ns/1ps

module dramController (
	input  logic                CLK,
	input  logic                arstN,
	input  ramSysPkg::addrT     A,
	input  logic                nWE,
	input  logic                nAS,
	input  logic                nLDS,
	input  logic                nUDS,
	input  logic                BACT,
	input  logic                RAMCS,
	input  logic                ROMCS,
	input  logic                RefReq,
	input  logic                RefUrgent,
	output logic                Ready,
	output logic                RefAck,
	output ramSysPkg::dramAddrT RA,
	output logic                nRAS,
	output logic                nCAS,
	output logic                nLWE,
	output logic                nUWE,
	output logic                nOE,
	output logic                nROMCS,
	output logic                nROMWE
);

	import ramSysPkg::*;

	dramStateE state;
	logic      once; // The RAM access of this bus cycle has been done
	logic      ramReady;
	logic      raSel; // Selects the column address and drives nCAS
	logic      ramDis1; // Set by the sequencer for the length of a refresh
	logic      ramDis2; // Holds RAM off for the rest of a cycle interrupted by refresh
	logic      ramEn;
	logic      refRas;
	logic      bactR;
	logic      refStart;
	logic      accStart;
	logic      preStart;

	assign ramEn = !(ramDis1 || ramDis2);

	// Flash strobes come straight from the bus
	assign nROMCS = ~ROMCS;
	assign nOE = ~(~nAS && nWE);
	assign nROMWE = ~(~nAS && ~nWE);

	// CPU RAS is held off while refresh owns the DRAM
	assign nRAS = ~((~nAS && RAMCS && ramEn && ~refRas) || refRas);
	assign nLWE = ~(~nAS && ~nWE && ~nLDS && ramEn);
	assign nUWE = ~(~nAS && ~nWE && ~nUDS && ramEn);

	// Row and column address multiplexer
	assign RA[11] = A[19];
	assign RA[10] = A[21];
	assign RA[9] = raSel ? A[20] : A[19];
	assign RA[8] = (raSel && RAMCS) ? A[9] : A[18]; // Column bit 8 only for a RAM select
	assign RA[7:0] = raSel ? A[8:1] : A[17:10];

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			bactR <= 1'b0;
		end else begin
			bactR <= BACT;
		end
	end

	// Refresh start rules, in priority order
	// A normal refresh only slips in at the first cycle of a non-RAM bus cycle
	assign refStart = (BACT && RefReq && ~RAMCS && ~bactR) ||
		(~BACT && RefUrgent) ||
		(BACT && RefUrgent && ~RAMCS);
	assign accStart = BACT && RAMCS && ~once; // A fresh RAM access wins over urgent refresh
	assign preStart = BACT && RAMCS && RefUrgent;

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			once <= 1'b0;
		end else if (~BACT) begin
			once <= 1'b0;
		end else if (state == stIdle && RAMCS) begin
			once <= 1'b1;
		end
	end

	// Once a long RAM cycle has been cut by refresh, RAS stays off until the cycle ends
	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			ramDis2 <= 1'b0;
		end else if (~BACT) begin
			ramDis2 <= 1'b0;
		end else if (RefUrgent && once &&
			((state == stIdle && RAMCS) || state == stRecover)) begin
			ramDis2 <= 1'b1;
		end
	end

	always_ff @(posedge CLK or negedge arstN) begin
		if (!arstN) begin
			state <= stIdle;
			ramReady <= 1'b0;
			raSel <= 1'b0;
			ramDis1 <= 1'b0;
			refRas <= 1'b0;
		end else begin
			ramReady <= 1'b0; // Ready is only granted from stIdle and stRecover
			raSel <= 1'b0;
			refRas <= 1'b0;
			case (state)
				stIdle: begin
					if (refStart) begin
						state <= stRefCas;
						raSel <= 1'b1;
						ramDis1 <= 1'b1;
					end else if (accStart) begin
						state <= stAccRow;
						raSel <= 1'b1;
						ramDis1 <= 1'b0;
					end else if (preStart) begin
						state <= stPrecharge;
						ramDis1 <= 1'b1;
					end else begin
						ramReady <= 1'b1;
						ramDis1 <= 1'b0;
					end
				end
				stPrecharge: begin
					state <= stRefCas;
					raSel <= 1'b1;
				end
				stRefCas: begin
					state <= stRefRas1;
					raSel <= 1'b1;
					refRas <= 1'b1; // CAS went low half a cycle ago
				end
				stRefRas1: begin
					state <= stRefRas2;
					refRas <= 1'b1;
				end
				stRefRas2: state <= stRecover;
				stAccRow: begin
					state <= stAccCol;
					raSel <= 1'b1;
				end
				stAccCol: state <= stRecover;
				stRecover: begin
					if (RefUrgent) begin
						state <= BACT ? stPrecharge : stRefCas;
						raSel <= ~BACT;
						ramDis1 <= 1'b1;
					end else begin
						state <= stIdle;
						ramReady <= 1'b1;
						ramDis1 <= 1'b0;
					end
				end
				default: state <= stIdle;
			endcase
		end
	end

	// CAS trails the multiplexer switch by half a cycle
	always_ff @(negedge CLK or negedge arstN) begin
		if (!arstN) begin
			nCAS <= 1'b1;
		end else begin
			nCAS <= ~raSel;
		end
	end

	assign RefAck = refRas;
	assign Ready = ~RAMCS || ramReady;

	// A CPU write may never reach the DRAM while refresh RAS is active
	noWriteInRefresh: assert property (
		@(posedge CLK) disable iff (!arstN)
		refRas |-> (nLWE && nUWE)
	) else $error("Write enable active during refresh RAS");

	refAckTwoCycles: assert property (
		@(posedge CLK) disable iff (!arstN)
		$rose(RefAck) |=> RefAck ##1 !RefAck
	) else $error("RefAck was not exactly two cycles long");

	stateKnown: assert property (
		@(posedge CLK) disable iff (!arstN)
		!$isunknown(state)
	) else $error("Sequencer state is undefined");

endmodule

/* hw/memSubsystemTop.sv */
`timescale 1ns/1ps

module memSubsystemTop (
	input  logic                CLK,
	input  logic                arstN,
	input  ramSysPkg::addrT     A,
	input  logic                nAS,
	input  logic                nWE,
	input  logic                nLDS,
	input  logic                nUDS,
	output logic                Ready,
	output ramSysPkg::dramAddrT RA,
	output logic                nRAS,
	output logic                nCAS,
	output logic                nLWE,
	output logic                nUWE,
	output logic                nOE,
	output logic                nROMCS,
	output logic                nROMWE
);

	logic BACT;
	logic RAMCS;
	logic ROMCS;
	logic RefReq;
	logic RefUrgent;
	logic RefAck;

	busCycleDecoder uDecoder (
		.CLK   (CLK),
		.arstN (arstN),
		.A     (A),
		.nAS   (nAS),
		.BACT  (BACT),
		.RAMCS (RAMCS),
		.ROMCS (ROMCS)
	);

	refreshTimer uTimer (
		.CLK       (CLK),
		.arstN     (arstN),
		.RefAck    (RefAck),
		.RefReq    (RefReq),
		.RefUrgent (RefUrgent)
	);

	// The controller takes the bus strobes directly as well as the decoded cycle
	dramController uCtrl (
		.CLK       (CLK),
		.arstN     (arstN),
		.A         (A),
		.nWE       (nWE),
		.nAS       (nAS),
		.nLDS      (nLDS),
		.nUDS      (nUDS),
		.BACT      (BACT),
		.RAMCS     (RAMCS),
		.ROMCS     (ROMCS),
		.RefReq    (RefReq),
		.RefUrgent (RefUrgent),
		.Ready     (Ready),
		.RefAck    (RefAck),
		.RA        (RA),
		.nRAS      (nRAS),
		.nCAS      (nCAS),
		.nLWE      (nLWE),
		.nUWE      (nUWE),
		.nOE       (nOE),
		.nROMCS    (nROMCS),
		.nROMWE    (nROMWE)
	);

endmodule

/* verification/memSubsystemTb.sv */
`timescale 1ns/1ps

module memSubsystemTb;

	import ramSysPkg::*;

	localparam int tableLen = 11;
	localparam int randCount = 12;
	localparam int resetCycles = 8;
	localparam int trafficPeriods = 6;
	localparam int settlePeriods = 8; // Idle time that brings the pending count to its idle level
	localparam int idlePeriods = 20;
	localparam int watchdogCycles = (tableLen + randCount) * 200 +
		(trafficPeriods + settlePeriods + idlePeriods + 2) * refreshPeriod + resetCycles;

	logic     CLK;
	logic     arstN;
	addrT     A;
	logic     nAS;
	logic     nWE;
	logic     nLDS;
	logic     nUDS;
	logic     Ready;
	dramAddrT RA;
	logic     nRAS;
	logic     nCAS;
	logic     nLWE;
	logic     nUWE;
	logic     nOE;
	logic     nROMCS;
	logic     nROMWE;

	addrT   tabAddr [tableLen];
	logic   tabWrite [tableLen];
	logic   tabLds [tableLen];
	logic   tabUds [tableLen];
	regionT tabRegion [tableLen];
	int     tabFill;

	logic [31:0] lcgState;
	int          cycleCount;
	int          refreshCount; // Refresh RAS falls seen inside the idle window
	int          errors;
	logic        countIdle;
	logic        prevNRas;
	logic        prevNCas;
	logic        refRasNow;

	memSubsystemTop u_dut (
		.CLK(CLK), .arstN(arstN), .A(A), .nAS(nAS),
		.nWE(nWE), .nLDS(nLDS), .nUDS(nUDS), .Ready(Ready),
		.RA(RA), .nRAS(nRAS), .nCAS(nCAS), .nLWE(nLWE),
		.nUWE(nUWE), .nOE(nOE), .nROMCS(nROMCS), .nROMWE(nROMWE)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;

	task automatic stopOnFailure();
		$display("TEST RESULT: FAIL");
		$fatal(1, "Simulation stopped on failure");
	endtask

	task automatic compareValue(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		if (actual !== expected) begin
			errors++;
			$display("ERROR at %0.1f ns: %s expected 0x%0h, got 0x%0h",
				$realtime, name, expected, actual);
			stopOnFailure();
		end
	endtask

	function automatic logic [31:0] nextRand();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	// Row is A19, A21, A19..A10 and column is A19, A21, A20, A9..A1
	function automatic dramAddrT rowOf(input addrT addr);
		return {addr[19], addr[21], addr[19:10]};
	endfunction

	function automatic dramAddrT colOf(input addrT addr);
		return {addr[19], addr[21], addr[20], addr[9:1]};
	endfunction

	task automatic addEntry(input addrT addr, input logic write, input logic lds,
		input logic uds, input regionT region);
		tabAddr[tabFill] = addr;
		tabWrite[tabFill] = write;
		tabLds[tabFill] = lds;
		tabUds[tabFill] = uds;
		tabRegion[tabFill] = region;
		tabFill++;
	endtask

	task automatic nextCycle();
		@(posedge CLK);
		#0.5;
	endtask

	// Samples once per cycle, late in the low phase when nCAS has settled
	task automatic sampleCycle();
		@(negedge CLK);
		#1;
		cycleCount++;
		// Refresh RAS falls right after a sample with CAS low and RAS high
		refRasNow = !nRAS && (refRasNow || (!prevNCas && prevNRas));
		if (refRasNow) begin
			compareValue("nLWE during refresh RAS", 1, nLWE);
			compareValue("nUWE during refresh RAS", 1, nUWE);
		end
		if (!nRAS && prevNRas && nAS) begin
			compareValue("nCAS at idle RAS fall", 0, nCAS);
			if (countIdle) begin
				refreshCount++;
			end
		end
		prevNRas = nRAS;
		prevNCas = nCAS;
	endtask

	task automatic busCycle(input addrT addr, input logic write, input logic lds,
		input logic uds, input regionT region);
		logic rowChecked;
		logic lastRow;
		logic accessDone;
		rowChecked = 1'b0;
		lastRow = 1'b0;
		accessDone = 1'b0;
		nextCycle();
		A = addr;
		nWE = !write;
		nLDS = lds;
		nUDS = uds;
		nAS = 1'b0;
		sampleCycle();
		if (region == romRegion) begin
			compareValue("Ready", 1, Ready); // Flash answers at once
			compareValue("nROMCS", 0, nROMCS);
			compareValue("nOE", write, nOE);
			compareValue("nROMWE", !write, nROMWE);
			if (!refRasNow) begin
				compareValue("nRAS", 1, nRAS);
			end
		end else begin
			// A CPU column phase always follows a row phase, refresh never does
			while (!accessDone) begin
				if (!nRAS && !nCAS && lastRow) begin
					accessDone = 1'b1;
					compareValue("RA column", colOf(addr), RA);
					compareValue("nLWE", write ? lds : 1'b1, nLWE);
					compareValue("nUWE", write ? uds : 1'b1, nUWE);
					compareValue("nOE", write, nOE);
					compareValue("nROMCS", 1, nROMCS);
				end else begin
					if (!nRAS && nCAS && !rowChecked) begin
						compareValue("RA row", rowOf(addr), RA);
						rowChecked = 1'b1;
					end
					lastRow = !nRAS && nCAS;
					nextCycle();
					sampleCycle();
				end
			end
			while (!Ready) begin
				nextCycle();
				sampleCycle();
			end
		end
		nextCycle();
		nAS = 1'b1;
		nWE = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		sampleCycle();
	endtask

	initial begin
		logic [31:0] r;
		addrT        addr;
		logic        lds;
		int          startCycle;
		arstN = 1'b0;
		A = '0;
		nAS = 1'b1;
		nWE = 1'b1;
		nLDS = 1'b1;
		nUDS = 1'b1;
		lcgState = 32'd25131;
		cycleCount = 0;
		refreshCount = 0;
		errors = 0;
		countIdle = 1'b0;
		prevNRas = 1'b1;
		prevNCas = 1'b1;
		refRasNow = 1'b0;
		tabFill = 0;
		addEntry(23'h0A5A5A, 1'b1, 1'b0, 1'b0, ramRegion);
		addEntry(23'h1F0F0F, 1'b1, 1'b0, 1'b1, ramRegion);
		addEntry(23'h055555, 1'b1, 1'b1, 1'b0, ramRegion);
		addEntry(23'h12AAAA, 1'b0, 1'b0, 1'b0, ramRegion);
		addEntry(23'h1FFFFF, 1'b0, 1'b0, 1'b0, ramRegion);
		addEntry(23'h000000, 1'b1, 1'b0, 1'b0, ramRegion);
		addEntry(23'h0C3001, 1'b0, 1'b0, 1'b1, ramRegion);
		addEntry(23'h200000, 1'b0, 1'b0, 1'b0, romRegion);
		addEntry(23'h2ABCDE, 1'b1, 1'b0, 1'b0, romRegion);
		addEntry(23'h3FFFFF, 1'b0, 1'b0, 1'b0, romRegion);
		addEntry(23'h312345, 1'b1, 1'b1, 1'b0, romRegion);

		repeat (resetCycles) @(posedge CLK);
		#0.5;
		arstN = 1'b1;
		sampleCycle();
		compareValue("nRAS after reset", 1, nRAS);
		compareValue("nCAS after reset", 1, nCAS);
		compareValue("nLWE after reset", 1, nLWE);
		compareValue("nUWE after reset", 1, nUWE);
		compareValue("nOE after reset", 1, nOE);
		compareValue("nROMCS after reset", 1, nROMCS);
		compareValue("nROMWE after reset", 1, nROMWE);
		compareValue("Ready after reset", 1, Ready);

		for (int i = 0; i < tableLen; i++) begin
			busCycle(tabAddr[i], tabWrite[i], tabLds[i], tabUds[i], tabRegion[i]);
		end

		// Random addresses over both regions, bit 23 clear keeps them mapped
		for (int i = 0; i < randCount; i++) begin
			r = nextRand();
			addr = r[31:9];
			addr[23] = 1'b0;
			lds = (r[7] && r[6]) ? 1'b0 : r[7]; // The CPU always drives one strobe
			busCycle(addr, r[8], lds, r[6], addr[23:22]);
		end

		startCycle = cycleCount;
		while (cycleCount - startCycle < trafficPeriods * refreshPeriod) begin
			r = nextRand();
			addr = r[31:9];
			addr[23:22] = ramRegion;
			lds = (r[7] && r[6]) ? 1'b0 : r[7]; // The CPU always drives one strobe
			busCycle(addr, r[8], lds, r[6], ramRegion);
		end

		repeat (settlePeriods * refreshPeriod) begin
			nextCycle();
			sampleCycle();
		end
		countIdle = 1'b1;
		repeat (idlePeriods * refreshPeriod) begin
			nextCycle();
			sampleCycle();
		end
		countIdle = 1'b0;
		if (refreshCount < idlePeriods - 1 || refreshCount > idlePeriods + 1) begin
			errors++;
			$display("Idle refresh count of %0d is not within one of %0d",
				refreshCount, idlePeriods);
		end

		if (errors == 0) begin
			$display("TEST RESULT: PASS");
			$finish;
		end else begin
			stopOnFailure();
		end
	end

	initial begin
		repeat (watchdogCycles) @(posedge CLK);
		$display("Watchdog expired after %0d cycles before the test finished", watchdogCycles);
		stopOnFailure();
	end

endmodule

/* flist.f */
hw/ramSysPkg.sv
hw/busCycleDecoder.sv
hw/refreshTimer.sv
hw/dramController.sv
hw/memSubsystemTop.sv
verification/memSubsystemTb.sv

/* Bender.yml */
package:
  name: mem_subsystem

sources:
  - hw/ramSysPkg.sv
  - hw/busCycleDecoder.sv
  - hw/refreshTimer.sv
  - hw/dramController.sv
  - hw/memSubsystemTop.sv
  - target: test
    files:
      - verification/memSubsystemTb.sv
